//--- list.f
+incdir+hw
hw/bp_entry_pkg.sv
hw/bp_request_pkg.sv
hw/predictor_ram.sv
hw/branch_lookup.sv
hw/branch_update.sv
hw/branch_predictor.sv
test/branch_predictor_properties.sv
test/tb_branch_predictor.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_branch_predictor -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- test/tb_branch_predictor.sv
// Branch predictor testbench with a stimulus table, reference table model and row reports
`include "bp_config.svh"

module tb_branch_predictor;

    localparam int ACK_TIMEOUT     = 16;
    localparam int PREDICT_TIMEOUT = 8;

    typedef enum logic [1:0] {OP_LOOKUP, OP_UPDATE, OP_BOTH} op_t;

    // One stimulus row, expected values are the prediction seen afterwards
    typedef struct {
        op_t                   op;
        logic [`BP_ADDR_W-1:0] pc;
        logic [`BP_ADDR_W-1:0] target;
        logic                  taken;
        int                    hold;
        logic                  exp_hit;
        logic                  exp_taken;
        logic [`BP_ADDR_W-1:0] exp_target;
        logic [1:0]            exp_counter;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  fetch_valid;
    logic [`BP_ADDR_W-1:0] fetch_pc;
    logic                  predict_valid;
    logic                  predict_hit;
    logic                  predict_taken;
    logic [`BP_ADDR_W-1:0] predict_target;
    logic [1:0]            predict_counter;
    logic                  update_req;
    logic                  update_ack;
    logic [`BP_ADDR_W-1:0] update_pc;
    logic [`BP_ADDR_W-1:0] update_target;
    logic                  update_taken;
    logic                  update_hit;
    logic [1:0]            update_counter;

    row_t rows [$];
    int   error_count = 0;
    logic timed_out   = 1'b0;

    // Reference copy of the table, empty like the RAMs
    logic                  model_valid   [`BP_DEPTH] = '{default: '0};
    logic [`BP_TAG_W-1:0]  model_tag     [`BP_DEPTH] = '{default: '0};
    logic [`BP_ADDR_W-1:0] model_target  [`BP_DEPTH] = '{default: '0};
    logic [1:0]            model_counter [`BP_DEPTH] = '{default: '0};

    branch_predictor i_branch_predictor (
        .clk (clk), .rst (rst),
        .fetch_valid (fetch_valid), .fetch_pc (fetch_pc),
        .predict_valid (predict_valid), .predict_hit (predict_hit),
        .predict_taken (predict_taken), .predict_target (predict_target),
        .predict_counter (predict_counter),
        .update_req (update_req), .update_ack (update_ack),
        .update_pc (update_pc), .update_target (update_target),
        .update_taken (update_taken), .update_hit (update_hit),
        .update_counter (update_counter)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Word address, low bits select the entry
    function automatic logic [`BP_INDEX_W-1:0] index_of(input logic [`BP_ADDR_W-1:0] pc);
        logic [`BP_ADDR_W-1:0] word;
        word = pc >> `BP_PC_LSB;
        return word[`BP_INDEX_W-1:0];
    endfunction

    function automatic logic [`BP_TAG_W-1:0] tag_of(input logic [`BP_ADDR_W-1:0] pc);
        logic [`BP_ADDR_W-1:0] upper;
        upper = pc >> (`BP_PC_LSB + `BP_INDEX_W);
        return upper[`BP_TAG_W-1:0];
    endfunction

    // Fresh entries start weak, known ones move by one and clamp to 0..3
    function automatic logic [1:0] stepped_counter(input logic hit, input logic taken,
                                                   input logic [1:0] counter);
        int level;
        if (!hit) begin
            return taken ? 2'd2 : 2'd1;
        end
        level = taken ? int'(counter) + 1 : int'(counter) - 1;
        if (level > 3) begin
            level = 3;
        end
        if (level < 0) begin
            level = 0;
        end
        return 2'(level);
    endfunction

    task automatic add_row(input op_t op, input logic [31:0] pc, input logic [31:0] target,
                           input logic taken, input int hold, input logic exp_hit,
                           input logic exp_taken, input logic [31:0] exp_target,
                           input logic [1:0] exp_counter);
        row_t r;
        r = '{op, pc, target, taken, hold, exp_hit, exp_taken, exp_target, exp_counter};
        rows.push_back(r);
    endtask

    //////////////////////////////////////////////////
    // Waits and checks
    //////////////////////////////////////////////////

    task automatic wait_predict();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!predict_valid && waited < PREDICT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!predict_valid) begin
            $display("Timeout: no prediction within %0d cycles of a fetch", PREDICT_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    // Cycles counted from the edge that drove req
    task automatic wait_ack(input logic level, output int waited);
        waited = 0;
        @(negedge clk);
        while (update_ack !== level && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (update_ack !== level) begin
            $display("Timeout: update_ack stuck at %0b for %0d cycles", !level, ACK_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_prediction(input row_t r);
        assert (predict_hit === r.exp_hit) else begin
            $display("FAILED at %0t: hit %0b, expected %0b", $time, predict_hit, r.exp_hit);
            error_count++;
        end
        assert (predict_taken === r.exp_taken) else begin
            $display("FAILED at %0t: taken %0b, expected %0b", $time, predict_taken,
                     r.exp_taken);
            error_count++;
        end
        assert (predict_target === r.exp_target) else begin
            $display("FAILED at %0t: target %h, expected %h", $time, predict_target,
                     r.exp_target);
            error_count++;
        end
        assert (predict_counter === r.exp_counter) else begin
            $display("FAILED at %0t: counter %0d, expected %0d", $time, predict_counter,
                     r.exp_counter);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // Row operations
    //////////////////////////////////////////////////

    task automatic run_lookup(input row_t r);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc    <= r.pc;
        @(posedge clk);
        fetch_valid <= 1'b0;
        wait_predict();
        if (!timed_out) begin
            check_prediction(r);
        end
    endtask

    // Data stays put until the next request
    task automatic drive_update(input row_t r, input logic hit, input logic [1:0] counter);
        update_req     <= 1'b1;
        update_pc      <= r.pc;
        update_target  <= r.target;
        update_taken   <= r.taken;
        update_hit     <= hit;
        update_counter <= counter;
    endtask

    task automatic release_req();
        int waited;
        @(posedge clk);
        update_req <= 1'b0;
        wait_ack(1'b0, waited);
        assert (timed_out || waited == 1) else begin
            $display("FAILED at %0t: ack fell %0d cycles after req low", $time, waited);
            error_count++;
        end
    endtask

    task automatic handshake_update(input row_t r, input logic hit, input logic [1:0] counter);
        int waited;
        @(posedge clk);
        drive_update(r, hit, counter);
        wait_ack(1'b1, waited);
        if (!timed_out) begin
            assert (waited == 1) else begin
                $display("FAILED at %0t: ack rose after %0d cycles", $time, waited);
                error_count++;
            end
            // Requester stalls, ack must stay up
            for (int k = 0; k < r.hold; k++) begin
                @(negedge clk);
                assert (update_ack) else begin
                    $display("FAILED at %0t: ack dropped while req held", $time);
                    error_count++;
                end
            end
            release_req();
        end
    endtask

    // Write and read meet at the same index on one edge
    task automatic update_and_lookup(input row_t r, input logic hit, input logic [1:0] counter);
        int waited;
        @(posedge clk);
        drive_update(r, hit, counter);
        fetch_valid <= 1'b1;
        fetch_pc    <= r.pc;
        @(posedge clk);
        fetch_valid <= 1'b0;
        wait_predict();
        if (!timed_out) begin
            check_prediction(r);
            wait_ack(1'b1, waited);
        end
        if (!timed_out) begin
            release_req();
        end
    endtask

    task automatic execute_row(input row_t r);
        logic [`BP_INDEX_W-1:0] idx;
        logic                   hit;
        logic [1:0]             counter;
        idx     = index_of(r.pc);
        hit     = model_valid[idx] && (model_tag[idx] == tag_of(r.pc));
        counter = model_counter[idx];
        case (r.op)
            OP_LOOKUP: run_lookup(r);
            OP_UPDATE: begin
                handshake_update(r, hit, counter);
                if (!timed_out) begin
                    run_lookup(r);
                end
            end
            default: update_and_lookup(r, hit, counter);
        endcase
        // Every update rewrites the whole entry
        if (r.op != OP_LOOKUP) begin
            model_valid[idx]   = 1'b1;
            model_tag[idx]     = tag_of(r.pc);
            model_target[idx]  = r.target;
            model_counter[idx] = stepped_counter(hit, r.taken, counter);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus table and main sequence
    //////////////////////////////////////////////////

    initial begin
        int pass_rows;
        int fail_rows;
        int errors_before;
        pass_rows = 0;
        fail_rows = 0;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        update_req = 1'b0;
        update_pc = '0;
        update_target = '0;
        update_taken = 1'b0;
        update_hit = 1'b0;
        update_counter = '0;

        // Empty table misses
        add_row(OP_LOOKUP, 32'h0000_1040, '0, 0, 0, 0, 0, 32'h0000_0000, 0);
        add_row(OP_LOOKUP, 32'h0000_0ffc, '0, 0, 0, 0, 0, 32'h0000_0000, 0);
        // Allocate, saturate up, then walk down through the flip
        add_row(OP_UPDATE, 32'h0000_1040, 32'h0000_2000, 1, 0, 1, 1, 32'h0000_2000, 2);
        add_row(OP_UPDATE, 32'h0000_1040, 32'h0000_2000, 1, 0, 1, 1, 32'h0000_2000, 3);
        add_row(OP_UPDATE, 32'h0000_1040, 32'h0000_2000, 1, 0, 1, 1, 32'h0000_2000, 3);
        add_row(OP_UPDATE, 32'h0000_1040, 32'h0000_2000, 0, 0, 1, 1, 32'h0000_2000, 2);
        add_row(OP_UPDATE, 32'h0000_1040, 32'h0000_2000, 0, 0, 1, 0, 32'h0000_2000, 1);
        add_row(OP_UPDATE, 32'h0000_1040, 32'h0000_2000, 0, 0, 1, 0, 32'h0000_2000, 0);
        add_row(OP_UPDATE, 32'h0000_1040, 32'h0000_2000, 0, 0, 1, 0, 32'h0000_2000, 0);
        // Same index, other tag
        add_row(OP_LOOKUP, 32'h0000_5040, '0, 0, 0, 0, 0, 32'h0000_2000, 0);
        add_row(OP_UPDATE, 32'h0000_5040, 32'h0000_6000, 0, 0, 1, 0, 32'h0000_6000, 1);
        add_row(OP_LOOKUP, 32'h0000_1040, '0, 0, 0, 0, 0, 32'h0000_6000, 1);
        // Write-first forwarding
        add_row(OP_BOTH, 32'h0000_2200, 32'h0001_0000, 1, 0, 1, 1, 32'h0001_0000, 2);
        add_row(OP_BOTH, 32'h0000_2200, 32'h0002_0000, 0, 0, 1, 0, 32'h0002_0000, 1);
        // Held req, one write per request
        add_row(OP_UPDATE, 32'h0000_3108, 32'h0000_8000, 1, 4, 1, 1, 32'h0000_8000, 2);
        add_row(OP_UPDATE, 32'h0000_3108, 32'h0000_8000, 1, 6, 1, 1, 32'h0000_8000, 3);
        add_row(OP_LOOKUP, 32'h0000_3108, '0, 0, 0, 1, 1, 32'h0000_8000, 3);
        add_row(OP_LOOKUP, 32'h0000_3108, '0, 0, 0, 1, 1, 32'h0000_8000, 3);
        add_row(OP_UPDATE, 32'h0000_3108, 32'h0000_8000, 0, 3, 1, 1, 32'h0000_8000, 2);
        add_row(OP_LOOKUP, 32'h0000_3108, '0, 0, 0, 1, 1, 32'h0000_8000, 2);
        add_row(OP_LOOKUP, 32'h0000_0ffc, '0, 0, 0, 0, 0, 32'h0000_0000, 0);

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            if (!timed_out) begin
                errors_before = error_count;
                execute_row(rows[i]);
                if (error_count == errors_before && !timed_out) begin
                    pass_rows++;
                    $display("row %0d %s: ok", i, rows[i].op.name());
                end else begin
                    fail_rows++;
                    $display("row %0d %s: failed", i, rows[i].op.name());
                end
            end
        end

        $display("rows run %0d, passed %0d, failed %0d, check errors %0d",
                 pass_rows + fail_rows, pass_rows, fail_rows, error_count);
        if (error_count == 0 && fail_rows == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- test/branch_predictor_properties.sv
// Branch predictor bound checks on the update handshake, table writes and lookup latency
module branch_predictor_properties (
    input logic clk,
    input logic rst,
    input logic fetch_valid,
    input logic predict_valid,
    input logic update_req,
    input logic update_ack,
    input logic write_en
);

    //////////////////////////////////////////////////
    // Update handshake
    //////////////////////////////////////////////////

    // Ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(update_ack) |-> $past(update_req))
        else $error("update_ack rose without update_req");

    // Req low seen once, ack low on the next edge
    ack_release: assert property (@(posedge clk) disable iff (rst)
        (update_ack && !update_req) |=> !update_ack)
        else $error("update_ack not released one cycle after update_req fell");

    // Held req must not rewrite the tables
    // Only the first cycle of a request writes
    write_on_req_start: assert property (@(posedge clk) disable iff (rst)
        write_en |-> !$past(update_req))
        else $error("table write on a later cycle of a held update_req");

    //////////////////////////////////////////////////
    // Lookup timing
    //////////////////////////////////////////////////

    // Prediction exactly one cycle after fetch
    predict_latency: assert property (@(posedge clk) disable iff (rst)
        predict_valid == $past(fetch_valid))
        else $error("predict_valid does not follow fetch_valid by one cycle");

endmodule

// Internal write strobe picked up in the top's scope
bind branch_predictor branch_predictor_properties i_branch_predictor_properties (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid   (fetch_valid),
    .predict_valid (predict_valid),
    .update_req    (update_req),
    .update_ack    (update_ack),
    .write_en      (write_en)
);

//--- hw/branch_predictor.sv
// Branch predictor top with lookup, update and the target and counter tables
`include "bp_config.svh"

module branch_predictor (
    input  logic                   clk,
    input  logic                   rst,

    // Fetch lookup
    input  logic                   fetch_valid,
    input  logic [`BP_ADDR_W-1:0]  fetch_pc,
    output logic                   predict_valid,
    output logic                   predict_hit,
    output logic                   predict_taken,
    output logic [`BP_ADDR_W-1:0]  predict_target,
    output bp_entry_pkg::counter_t predict_counter,

    // Execute update
    input  logic                   update_req,
    output logic                   update_ack,
    input  logic [`BP_ADDR_W-1:0]  update_pc,
    input  logic [`BP_ADDR_W-1:0]  update_target,
    input  logic                   update_taken,
    input  logic                   update_hit,
    input  bp_entry_pkg::counter_t update_counter
);

    // Shared read side, driven by lookup
    bp_request_pkg::bp_index_t   read_addr;
    logic                        read_en;
    bp_entry_pkg::target_entry_t target_data;
    bp_entry_pkg::counter_t      counter_data;

    // Shared write side, driven by update
    bp_request_pkg::bp_index_t   write_addr;
    logic                        write_en;
    bp_entry_pkg::target_entry_t target_write;
    bp_entry_pkg::counter_t      counter_write;

    //////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////

    branch_lookup i_branch_lookup (
        .clk             (clk),
        .rst             (rst),
        .fetch_valid     (fetch_valid),
        .fetch_pc        (fetch_pc),
        .read_addr       (read_addr),
        .read_en         (read_en),
        .target_data     (target_data),
        .counter_data    (counter_data),
        .predict_valid   (predict_valid),
        .predict_hit     (predict_hit),
        .predict_taken   (predict_taken),
        .predict_target  (predict_target),
        .predict_counter (predict_counter)
    );

    branch_update i_branch_update (
        .clk            (clk),
        .rst            (rst),
        .update_req     (update_req),
        .update_ack     (update_ack),
        .update_pc      (update_pc),
        .update_target  (update_target),
        .update_taken   (update_taken),
        .update_hit     (update_hit),
        .update_counter (update_counter),
        .write_addr     (write_addr),
        .write_en       (write_en),
        .target_write   (target_write),
        .counter_write  (counter_write)
    );

    //////////////////////////////////////////////////
    // Tables
    //////////////////////////////////////////////////

    // Valid, tag and target
    predictor_ram #(
        .DEPTH   (`BP_DEPTH),
        .entry_t (bp_entry_pkg::target_entry_t)
    ) i_target_ram (
        .clk        (clk),
        .rst        (rst),
        .write_addr (write_addr),
        .write_en   (write_en),
        .write_data (target_write),
        .read_addr  (read_addr),
        .read_en    (read_en),
        .read_data  (target_data)
    );

    // Direction counters
    predictor_ram #(
        .DEPTH   (`BP_DEPTH),
        .entry_t (bp_entry_pkg::counter_t)
    ) i_counter_ram (
        .clk        (clk),
        .rst        (rst),
        .write_addr (write_addr),
        .write_en   (write_en),
        .write_data (counter_write),
        .read_addr  (read_addr),
        .read_en    (read_en),
        .read_data  (counter_data)
    );

endmodule

//--- hw/branch_update.sv
// Branch update stage with a four-phase req/ack slave and saturating counter step
`include "bp_config.svh"

module branch_update (
    input  logic                        clk,
    input  logic                        rst,

    // Four-phase handshake with execute
    input  logic                        update_req,
    output logic                        update_ack,

    // Resolved branch, stable while req is high
    input  logic [`BP_ADDR_W-1:0]       update_pc,
    input  logic [`BP_ADDR_W-1:0]       update_target,
    input  logic                        update_taken,
    input  logic                        update_hit,
    input  bp_entry_pkg::counter_t      update_counter,

    // Write port of both tables
    output bp_request_pkg::bp_index_t   write_addr,
    output logic                        write_en,
    output bp_entry_pkg::target_entry_t target_write,
    output bp_entry_pkg::counter_t      counter_write
);

    // Request seen while ack is still low
    logic new_req;

    assign new_req = update_req && !update_ack;

    //////////////////////////////////////////////////
    // Table write
    //////////////////////////////////////////////////

    // Write lands on the same edge that raises ack
    // Held req keeps ack high, so no second write
    assign write_en   = new_req;
    assign write_addr = bp_request_pkg::pc_index(update_pc);

    // Always a valid entry with the pc's tag
    assign target_write.valid  = 1'b1;
    assign target_write.tag    = bp_request_pkg::pc_tag(update_pc);
    assign target_write.target = update_target;

    // Counter for the rewritten entry
    always_comb begin
        if (!update_hit) begin
            // Fresh entry starts weak in the resolved direction
            if (update_taken) begin
                counter_write = bp_entry_pkg::counter_weak_taken;
            end else begin
                counter_write = bp_entry_pkg::counter_weak_not_taken;
            end
        end else if (update_taken) begin
            // Step up, stop at 3
            if (update_counter == bp_entry_pkg::counter_max) begin
                counter_write = bp_entry_pkg::counter_max;
            end else begin
                counter_write = update_counter + 2'd1;
            end
        end else begin
            // Step down, stop at 0
            if (update_counter == bp_entry_pkg::counter_min) begin
                counter_write = bp_entry_pkg::counter_min;
            end else begin
                counter_write = update_counter - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    // Ack rises with the write, held until req drops
    // Falls on the edge that first sees req low
    always_ff @(posedge clk) begin
        if (rst) begin
            update_ack <= 1'b0;
        end else if (new_req) begin
            update_ack <= 1'b1;
        end else if (!update_req) begin
            update_ack <= 1'b0;
        end
    end

endmodule

//--- hw/branch_lookup.sv
// Branch lookup stage that splits the fetch address and forms the prediction
`include "bp_config.svh"

module branch_lookup (
    input  logic                        clk,
    input  logic                        rst,

    // Fetch side
    input  logic                        fetch_valid,
    input  logic [`BP_ADDR_W-1:0]       fetch_pc,

    // Read port of both tables
    output bp_request_pkg::bp_index_t   read_addr,
    output logic                        read_en,
    input  bp_entry_pkg::target_entry_t target_data,
    input  bp_entry_pkg::counter_t      counter_data,

    // Prediction, one cycle after the fetch
    output logic                        predict_valid,
    output logic                        predict_hit,
    output logic                        predict_taken,
    output logic [`BP_ADDR_W-1:0]       predict_target,
    output bp_entry_pkg::counter_t      predict_counter
);

    // Tag of the lookup in flight
    bp_request_pkg::bp_tag_t lookup_tag;

    // Stored tag equals the fetch tag
    logic tag_match;

    //////////////////////////////////////////////////
    // Address split and table read
    //////////////////////////////////////////////////

    // Index goes straight to the RAMs
    // Their output register gives the one cycle latency
    assign read_addr = bp_request_pkg::pc_index(fetch_pc);
    assign read_en   = fetch_valid;

    // Tag lines up with the RAM output
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            lookup_tag <= bp_request_pkg::pc_tag(fetch_pc);
        end
    end

    // Result valid one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            predict_valid <= 1'b0;
        end else begin
            predict_valid <= fetch_valid;
        end
    end

    //////////////////////////////////////////////////
    // Prediction
    //////////////////////////////////////////////////

    assign tag_match = (target_data.tag == lookup_tag);

    // Hit needs a valid entry with our tag
    assign predict_hit = target_data.valid && tag_match;

    // Direction from the counter upper bit
    // Never taken on a miss
    assign predict_taken = predict_hit && counter_data[1];

    // Stored fields passed on as read
    assign predict_target  = target_data.target;
    assign predict_counter = counter_data;

endmodule

//--- hw/predictor_ram.sv
// Write-first block RAM with one read port, one write port and a typed payload
`include "bp_config.svh"

module predictor_ram #(
    parameter int  DEPTH   = `BP_DEPTH,
    parameter type entry_t = logic
) (
    input  logic                      clk,
    input  logic                      rst,
    input  bp_request_pkg::bp_index_t write_addr,
    input  logic                      write_en,
    input  entry_t                    write_data,
    input  bp_request_pkg::bp_index_t read_addr,
    input  logic                      read_en,
    output entry_t                    read_data
);

    // Storage array, empty at power up
    // Zero valid bit reads as no entry
    entry_t mem [DEPTH] = '{default: '0};

    // Write port
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // Registered read, held while read_en is low
    // Same-cycle write to the read index is forwarded
    always_ff @(posedge clk) begin
        if (rst) begin
            read_data <= '0;
        end else if (read_en) begin
            if (write_en && (write_addr == read_addr)) begin
                read_data <= write_data;
            end else begin
                read_data <= mem[read_addr];
            end
        end
    end

endmodule

//--- hw/bp_request_pkg.sv
// Branch predictor request types for table indices and tags of fetch and update traffic
`include "bp_config.svh"

package bp_request_pkg;

    //////////////////////////////////////////////////
    // Address fields
    //////////////////////////////////////////////////

    // Direct-mapped table index
    typedef logic [`BP_INDEX_W-1:0] bp_index_t;

    // Address tag kept next to the target
    typedef logic [`BP_TAG_W-1:0] bp_tag_t;

    // Index sits right above the word offset
    function automatic bp_index_t pc_index(input logic [`BP_ADDR_W-1:0] pc);
        return pc[`BP_PC_LSB +: `BP_INDEX_W];
    endfunction

    // Tag sits right above the index
    function automatic bp_tag_t pc_tag(input logic [`BP_ADDR_W-1:0] pc);
        return pc[`BP_PC_LSB + `BP_INDEX_W +: `BP_TAG_W];
    endfunction

endpackage

//--- hw/bp_entry_pkg.sv
// Branch predictor storage types for the target table and the counter table
`include "bp_config.svh"

package bp_entry_pkg;

    //////////////////////////////////////////////////
    // Target table
    //////////////////////////////////////////////////

    // Tag and target entry, 41 bits with the default widths
    typedef struct packed {
        logic                  valid;
        logic [`BP_TAG_W-1:0]  tag;
        logic [`BP_ADDR_W-1:0] target;
    } target_entry_t;

    //////////////////////////////////////////////////
    // Counter table
    //////////////////////////////////////////////////

    // Two-bit saturating direction counter
    // Upper bit set means taken
    typedef logic [1:0] counter_t;

    // Starting point for a freshly allocated entry
    localparam counter_t counter_weak_not_taken = 2'd1;
    localparam counter_t counter_weak_taken     = 2'd2;

    // Saturation limits
    localparam counter_t counter_min = 2'd0;
    localparam counter_t counter_max = 2'd3;

endpackage

//--- hw/bp_config.svh
// Branch predictor configuration macros for table geometry and address widths
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

//////////////////////////////////////////////////
// Table geometry
//////////////////////////////////////////////////

// Number of direct-mapped entries
`define BP_DEPTH 256

// Index bits, log2 of the depth
`define BP_INDEX_W ($clog2(`BP_DEPTH))

//////////////////////////////////////////////////
// Address fields
//////////////////////////////////////////////////

// Fetch and target address width
`define BP_ADDR_W 32

// Stored tag bits, taken just above the index
`define BP_TAG_W 8

// Word aligned instructions, two offset bits skipped
`define BP_PC_LSB 2

`endif
